//--- eth_dispatch.sv
// Routes each packet to the CPU when its destination MAC matches, else to
// the crossover port. The route is picked on the first beat and held.
`timescale 1ns/1ns

module eth_dispatch (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [eth_switch_pkg::DATA_W-1:0]  i_tdata,
  input  logic [eth_switch_pkg::USER_W-1:0]  i_tuser,
  input  logic                               i_tlast,
  input  logic                               i_tvalid,
  output logic                               o_tready,
  input  logic [eth_switch_pkg::MAC_W-1:0]   i_active_mac,
  output logic [eth_switch_pkg::DATA_W-1:0]  o_e2c_tdata,
  output logic [eth_switch_pkg::USER_W-1:0]  o_e2c_tuser,
  output logic                               o_e2c_tlast,
  output logic                               o_e2c_tvalid,
  input  logic                               i_e2c_tready,
  output logic [eth_switch_pkg::DATA_W-1:0]  o_xo_tdata,
  output logic [eth_switch_pkg::USER_W-1:0]  o_xo_tuser,
  output logic                               o_xo_tlast,
  output logic                               o_xo_tvalid,
  input  logic                               i_xo_tready
);

  import eth_switch_pkg::*;

  logic   sop;
  logic   in_fire;
  route_t route_q;
  route_t route;

  // First beat decides, later beats follow the stored route
  always_comb begin
    if (sop) begin
      route = (i_tdata[MAC_W-1:0] == i_active_mac) ? ROUTE_CPU : ROUTE_XO;
    end else begin
      route = route_q;
    end
  end

  assign o_tready = (route == ROUTE_CPU) ? i_e2c_tready : i_xo_tready;
  assign in_fire  = i_tvalid && o_tready;

  always_ff @(posedge clk) begin
    if (reset) begin
      sop     <= 1'b1;
      route_q <= ROUTE_CPU;
    end else if (in_fire) begin
      sop <= i_tlast;
      if (sop) begin
        route_q <= route;
      end
    end
  end

  // Payload fans out to both ports, only valid is steered
  assign o_e2c_tdata  = i_tdata;
  assign o_e2c_tuser  = i_tuser;
  assign o_e2c_tlast  = i_tlast;
  assign o_e2c_tvalid = i_tvalid && (route == ROUTE_CPU);

  assign o_xo_tdata  = i_tdata;
  assign o_xo_tuser  = i_tuser;
  assign o_xo_tlast  = i_tlast;
  assign o_xo_tvalid = i_tvalid && (route == ROUTE_XO);

endmodule

//--- eth_packet_gate.sv
// Store-and-forward gate: a packet leaves only after its last beat is in.
// Packets flagged with the user error bit on the last beat are dropped.
// Packets longer than 64 beats are not supported and will stall the input.
`timescale 1ns/1ns

module eth_packet_gate (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [eth_switch_pkg::DATA_W-1:0]  i_tdata,
  input  logic [eth_switch_pkg::USER_W-1:0]  i_tuser,
  input  logic                               i_tlast,
  input  logic                               i_tvalid,
  output logic                               i_tready,
  output logic [eth_switch_pkg::DATA_W-1:0]  o_tdata,
  output logic [eth_switch_pkg::USER_W-1:0]  o_tuser,
  output logic                               o_tlast,
  output logic                               o_tvalid,
  input  logic                               o_tready
);

  import eth_switch_pkg::*;

  localparam int DEPTH  = 1 << GATE_AW;
  localparam int WORD_W = DATA_W + USER_W + 1;

  // One extra pointer bit tells full from empty
  logic [GATE_AW:0]  wr_ptr;
  logic [GATE_AW:0]  commit_ptr;
  logic [GATE_AW:0]  rd_ptr;
  logic [GATE_AW:0]  fill;
  logic [WORD_W-1:0] mem [DEPTH];
  logic [WORD_W-1:0] rd_word;
  logic              wr_fire;
  logic              rd_fire;

  assign fill     = wr_ptr - rd_ptr;
  assign i_tready = !fill[GATE_AW];
  assign wr_fire  = i_tvalid && i_tready;

  // Only beats of fully received clean packets are visible
  assign o_tvalid = (rd_ptr != commit_ptr);
  assign rd_fire  = o_tvalid && o_tready;

  assign rd_word                     = mem[rd_ptr[GATE_AW-1:0]];
  assign {o_tlast, o_tuser, o_tdata} = rd_word;

  //////////////////////////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr[GATE_AW-1:0]] <= {i_tlast, i_tuser, i_tdata};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
    end else if (wr_fire) begin
      if (!i_tlast) begin
        wr_ptr <= wr_ptr + 1'b1;
      end else if (i_tuser[USER_ERR_BIT]) begin
        // Bad packet, throw away everything since the last commit
        wr_ptr <= commit_ptr;
      end else begin
        wr_ptr     <= wr_ptr + 1'b1;
        commit_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (rd_fire) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- eth_reg_file.sv
// MAC and bridge registers behind a simple request/response register port.
// Writes to unmapped offsets are dropped; unmapped reads get no response.
`timescale 1ns/1ns

module eth_reg_file (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               i_reg_wr_req,
  input  logic [eth_switch_pkg::REG_AW-1:0]  i_reg_wr_addr,
  input  logic [eth_switch_pkg::REG_DW-1:0]  i_reg_wr_data,
  input  logic                               i_reg_rd_req,
  input  logic [eth_switch_pkg::REG_AW-1:0]  i_reg_rd_addr,
  output logic                               o_reg_rd_resp,
  output logic [eth_switch_pkg::REG_DW-1:0]  o_reg_rd_data,
  output logic [eth_switch_pkg::MAC_W-1:0]   o_active_mac
);

  import eth_switch_pkg::*;

  logic [MAC_W-1:0]  mac_reg;
  logic [MAC_W-1:0]  bridge_mac_reg;
  logic              bridge_en;
  logic              rd_hit;
  logic [REG_DW-1:0] rd_value;

  // Bridge mode swaps in the second MAC for packet matching
  assign o_active_mac = bridge_en ? bridge_mac_reg : mac_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      mac_reg        <= DEFAULT_MAC;
      bridge_mac_reg <= DEFAULT_MAC;
      bridge_en      <= 1'b0;
    end else if (i_reg_wr_req) begin
      case (i_reg_wr_addr)
        REG_MAC_LSB:        mac_reg[31:0]         <= i_reg_wr_data;
        REG_MAC_MSB:        mac_reg[47:32]        <= i_reg_wr_data[15:0];
        REG_BRIDGE_MAC_LSB: bridge_mac_reg[31:0]  <= i_reg_wr_data;
        REG_BRIDGE_MAC_MSB: bridge_mac_reg[47:32] <= i_reg_wr_data[15:0];
        REG_BRIDGE_ENABLE:  bridge_en             <= i_reg_wr_data[0];
        default: ;
      endcase
    end
  end

  // Read decode, upper bits of the narrow registers read as zero
  always_comb begin
    rd_hit   = 1'b1;
    rd_value = '0;
    case (i_reg_rd_addr)
      REG_MAC_LSB:        rd_value = mac_reg[31:0];
      REG_MAC_MSB:        rd_value = {16'b0, mac_reg[47:32]};
      REG_BRIDGE_MAC_LSB: rd_value = bridge_mac_reg[31:0];
      REG_BRIDGE_MAC_MSB: rd_value = {16'b0, bridge_mac_reg[47:32]};
      REG_BRIDGE_ENABLE:  rd_value = {31'b0, bridge_en};
      default:            rd_hit   = 1'b0;
    endcase
  end

  // Response is a single-cycle pulse one clock after the request
  always_ff @(posedge clk) begin
    if (reset) begin
      o_reg_rd_resp <= 1'b0;
    end else begin
      o_reg_rd_resp <= i_reg_rd_req && rd_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reg_rd_req) begin
      o_reg_rd_data <= rd_value;
    end
  end

endmodule

//--- eth_switch.sv
// Ethernet port switch: packet gate, MAC dispatcher and transmit arbiter.
// No FIFOs on the CPU or crossover paths, back-pressure reaches the gate.
`timescale 1ns/1ns

module eth_switch (
  input  logic                               clk,
  input  logic                               reset,
  // Register port
  input  logic                               i_reg_wr_req,
  input  logic [eth_switch_pkg::REG_AW-1:0]  i_reg_wr_addr,
  input  logic [eth_switch_pkg::REG_DW-1:0]  i_reg_wr_data,
  input  logic                               i_reg_rd_req,
  input  logic [eth_switch_pkg::REG_AW-1:0]  i_reg_rd_addr,
  output logic                               o_reg_rd_resp,
  output logic [eth_switch_pkg::REG_DW-1:0]  o_reg_rd_data,
  // Ethernet receive
  input  logic [eth_switch_pkg::DATA_W-1:0]  i_eth_rx_tdata,
  input  logic [eth_switch_pkg::USER_W-1:0]  i_eth_rx_tuser,
  input  logic                               i_eth_rx_tlast,
  input  logic                               i_eth_rx_tvalid,
  output logic                               o_eth_rx_tready,
  // Ethernet transmit
  output logic [eth_switch_pkg::DATA_W-1:0]  o_eth_tx_tdata,
  output logic [eth_switch_pkg::USER_W-1:0]  o_eth_tx_tuser,
  output logic                               o_eth_tx_tlast,
  output logic                               o_eth_tx_tvalid,
  input  logic                               i_eth_tx_tready,
  // To CPU
  output logic [eth_switch_pkg::DATA_W-1:0]  o_e2c_tdata,
  output logic [eth_switch_pkg::USER_W-1:0]  o_e2c_tuser,
  output logic                               o_e2c_tlast,
  output logic                               o_e2c_tvalid,
  input  logic                               i_e2c_tready,
  // From CPU
  input  logic [eth_switch_pkg::DATA_W-1:0]  i_c2e_tdata,
  input  logic [eth_switch_pkg::USER_W-1:0]  i_c2e_tuser,
  input  logic                               i_c2e_tlast,
  input  logic                               i_c2e_tvalid,
  output logic                               o_c2e_tready,
  // Crossover out and in
  output logic [eth_switch_pkg::DATA_W-1:0]  o_xo_tdata,
  output logic [eth_switch_pkg::USER_W-1:0]  o_xo_tuser,
  output logic                               o_xo_tlast,
  output logic                               o_xo_tvalid,
  input  logic                               i_xo_tready,
  input  logic [eth_switch_pkg::DATA_W-1:0]  i_xi_tdata,
  input  logic [eth_switch_pkg::USER_W-1:0]  i_xi_tuser,
  input  logic                               i_xi_tlast,
  input  logic                               i_xi_tvalid,
  output logic                               o_xi_tready
);

  import eth_switch_pkg::*;

  logic [MAC_W-1:0]  active_mac;
  logic [DATA_W-1:0] gate_tdata;
  logic [USER_W-1:0] gate_tuser;
  logic              gate_tlast;
  logic              gate_tvalid;
  logic              gate_tready;

  eth_reg_file reg_file_i (
    .clk(clk), .reset(reset),
    .i_reg_wr_req(i_reg_wr_req), .i_reg_wr_addr(i_reg_wr_addr),
    .i_reg_wr_data(i_reg_wr_data),
    .i_reg_rd_req(i_reg_rd_req), .i_reg_rd_addr(i_reg_rd_addr),
    .o_reg_rd_resp(o_reg_rd_resp), .o_reg_rd_data(o_reg_rd_data),
    .o_active_mac(active_mac)
  );

  //////////////////////////////////////////////////////////////////////
  // Receive path
  //////////////////////////////////////////////////////////////////////

  eth_packet_gate packet_gate_i (
    .clk(clk), .reset(reset),
    .i_tdata(i_eth_rx_tdata), .i_tuser(i_eth_rx_tuser), .i_tlast(i_eth_rx_tlast),
    .i_tvalid(i_eth_rx_tvalid), .i_tready(o_eth_rx_tready),
    .o_tdata(gate_tdata), .o_tuser(gate_tuser), .o_tlast(gate_tlast),
    .o_tvalid(gate_tvalid), .o_tready(gate_tready)
  );

  eth_dispatch dispatch_i (
    .clk(clk), .reset(reset),
    .i_tdata(gate_tdata), .i_tuser(gate_tuser), .i_tlast(gate_tlast),
    .i_tvalid(gate_tvalid), .o_tready(gate_tready),
    .i_active_mac(active_mac),
    .o_e2c_tdata(o_e2c_tdata), .o_e2c_tuser(o_e2c_tuser), .o_e2c_tlast(o_e2c_tlast),
    .o_e2c_tvalid(o_e2c_tvalid), .i_e2c_tready(i_e2c_tready),
    .o_xo_tdata(o_xo_tdata), .o_xo_tuser(o_xo_tuser), .o_xo_tlast(o_xo_tlast),
    .o_xo_tvalid(o_xo_tvalid), .i_xo_tready(i_xo_tready)
  );

  //////////////////////////////////////////////////////////////////////
  // Transmit path
  //////////////////////////////////////////////////////////////////////

  eth_tx_arbiter tx_arbiter_i (
    .clk(clk), .reset(reset),
    .i_c2e_tdata(i_c2e_tdata), .i_c2e_tuser(i_c2e_tuser), .i_c2e_tlast(i_c2e_tlast),
    .i_c2e_tvalid(i_c2e_tvalid), .o_c2e_tready(o_c2e_tready),
    .i_xi_tdata(i_xi_tdata), .i_xi_tuser(i_xi_tuser), .i_xi_tlast(i_xi_tlast),
    .i_xi_tvalid(i_xi_tvalid), .o_xi_tready(o_xi_tready),
    .o_eth_tx_tdata(o_eth_tx_tdata), .o_eth_tx_tuser(o_eth_tx_tuser),
    .o_eth_tx_tlast(o_eth_tx_tlast), .o_eth_tx_tvalid(o_eth_tx_tvalid),
    .i_eth_tx_tready(i_eth_tx_tready)
  );

endmodule

//--- eth_switch_pkg.sv
// Shared widths, register map and state encodings for the Ethernet switch.
// The destination MAC is assumed to sit in bits 47:0 of a packet's first beat.
package eth_switch_pkg;

  // Stream widths
  localparam int DATA_W       = 64;
  localparam int USER_W       = 4;
  localparam int USER_ERR_BIT = 3;

  // MAC and register port widths
  localparam int MAC_W  = 48;
  localparam int REG_AW = 14;
  localparam int REG_DW = 32;

  // Packet gate depth is 2**GATE_AW beats
  localparam int GATE_AW = 6;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [REG_AW-1:0] REG_MAC_LSB        = 14'h0000;
  localparam logic [REG_AW-1:0] REG_MAC_MSB        = 14'h0004;
  localparam logic [REG_AW-1:0] REG_BRIDGE_MAC_LSB = 14'h1010;
  localparam logic [REG_AW-1:0] REG_BRIDGE_MAC_MSB = 14'h1014;
  localparam logic [REG_AW-1:0] REG_BRIDGE_ENABLE  = 14'h1020;

  // 00:80:2f:16:c5:2f
  localparam logic [MAC_W-1:0] DEFAULT_MAC = 48'h00802f16c52f;

  // Where the dispatcher sends a packet
  typedef enum logic [0:0] {
    ROUTE_CPU,
    ROUTE_XO
  } route_t;

  // Transmit arbiter grant
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_CPU,
    ARB_XO
  } arb_state_t;

endpackage

//--- eth_tx_arbiter.sv
// Merges CPU and crossover traffic onto Ethernet transmit a whole packet
// at a time. Ties go to the source not served last, CPU first after reset.
`timescale 1ns/1ns

module eth_tx_arbiter (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [eth_switch_pkg::DATA_W-1:0]  i_c2e_tdata,
  input  logic [eth_switch_pkg::USER_W-1:0]  i_c2e_tuser,
  input  logic                               i_c2e_tlast,
  input  logic                               i_c2e_tvalid,
  output logic                               o_c2e_tready,
  input  logic [eth_switch_pkg::DATA_W-1:0]  i_xi_tdata,
  input  logic [eth_switch_pkg::USER_W-1:0]  i_xi_tuser,
  input  logic                               i_xi_tlast,
  input  logic                               i_xi_tvalid,
  output logic                               o_xi_tready,
  output logic [eth_switch_pkg::DATA_W-1:0]  o_eth_tx_tdata,
  output logic [eth_switch_pkg::USER_W-1:0]  o_eth_tx_tuser,
  output logic                               o_eth_tx_tlast,
  output logic                               o_eth_tx_tvalid,
  input  logic                               i_eth_tx_tready
);

  import eth_switch_pkg::*;

  arb_state_t state;
  arb_state_t state_next;
  route_t     last_served;
  logic       tx_fire;

  always_comb begin
    state_next = state;
    case (state)
      ARB_IDLE: begin
        if (i_c2e_tvalid && i_xi_tvalid) begin
          state_next = (last_served == ROUTE_CPU) ? ARB_XO : ARB_CPU;
        end else if (i_c2e_tvalid) begin
          state_next = ARB_CPU;
        end else if (i_xi_tvalid) begin
          state_next = ARB_XO;
        end
      end
      // Hold the grant until the packet's last beat goes out
      ARB_CPU, ARB_XO: begin
        if (tx_fire && o_eth_tx_tlast) begin
          state_next = ARB_IDLE;
        end
      end
      default: state_next = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ARB_IDLE;
      last_served <= ROUTE_XO;
    end else begin
      state <= state_next;
      if (tx_fire && o_eth_tx_tlast) begin
        last_served <= (state == ARB_XO) ? ROUTE_XO : ROUTE_CPU;
      end
    end
  end

  // Output mux
  assign o_eth_tx_tdata  = (state == ARB_XO) ? i_xi_tdata : i_c2e_tdata;
  assign o_eth_tx_tuser  = (state == ARB_XO) ? i_xi_tuser : i_c2e_tuser;
  assign o_eth_tx_tlast  = (state == ARB_XO) ? i_xi_tlast : i_c2e_tlast;
  assign o_eth_tx_tvalid = ((state == ARB_CPU) && i_c2e_tvalid) ||
                           ((state == ARB_XO) && i_xi_tvalid);

  assign o_c2e_tready = (state == ARB_CPU) && i_eth_tx_tready;
  assign o_xi_tready  = (state == ARB_XO) && i_eth_tx_tready;
  assign tx_fire      = o_eth_tx_tvalid && i_eth_tx_tready;

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the Ethernet switch testbench with Verilator.
# Exits non-zero if the build fails or the simulation log reports failure.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary -f verilog.f --top-module tb_eth_switch \
  --Mdir obj_dir -o sim_eth_switch > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build did not complete"
  exit 1
fi

./obj_dir/sim_eth_switch > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

//--- tb_eth_switch.sv
// Directed testbench for the Ethernet switch top level.
// Packets are kept short (1 to 8 beats) so the 64-beat gate never overflows.
// Output readies toggle randomly for the whole run to exercise back-pressure.
`timescale 1ns/1ns

module tb_eth_switch;

  import eth_switch_pkg::*;

  localparam int BEAT_W  = DATA_W + USER_W + 1;
  localparam int TIMEOUT = 2000;

  logic clk;
  logic reset;
  logic i_reg_wr_req;
  logic [REG_AW-1:0] i_reg_wr_addr;
  logic [REG_DW-1:0] i_reg_wr_data;
  logic i_reg_rd_req;
  logic [REG_AW-1:0] i_reg_rd_addr;
  logic o_reg_rd_resp;
  logic [REG_DW-1:0] o_reg_rd_data;
  logic [DATA_W-1:0] i_eth_rx_tdata;
  logic [DATA_W-1:0] o_eth_tx_tdata;
  logic [DATA_W-1:0] o_e2c_tdata;
  logic [DATA_W-1:0] i_c2e_tdata;
  logic [DATA_W-1:0] o_xo_tdata;
  logic [DATA_W-1:0] i_xi_tdata;
  logic [USER_W-1:0] i_eth_rx_tuser;
  logic [USER_W-1:0] o_eth_tx_tuser;
  logic [USER_W-1:0] o_e2c_tuser;
  logic [USER_W-1:0] i_c2e_tuser;
  logic [USER_W-1:0] o_xo_tuser;
  logic [USER_W-1:0] i_xi_tuser;
  logic i_eth_rx_tlast;
  logic i_eth_rx_tvalid;
  logic o_eth_rx_tready;
  logic o_eth_tx_tlast;
  logic o_eth_tx_tvalid;
  logic i_eth_tx_tready;
  logic o_e2c_tlast;
  logic o_e2c_tvalid;
  logic i_e2c_tready;
  logic i_c2e_tlast;
  logic i_c2e_tvalid;
  logic o_c2e_tready;
  logic o_xo_tlast;
  logic o_xo_tvalid;
  logic i_xo_tready;
  logic i_xi_tlast;
  logic i_xi_tvalid;
  logic o_xi_tready;

  int seed;
  logic [31:0] ready_bits;
  logic [MAC_W-1:0] model_mac;
  route_t tx_src;

  // Expected beats as {last, user, data} with the port each should leave on
  logic [BEAT_W-1:0] rx_q[$];
  route_t rx_route_q[$];
  logic [BEAT_W-1:0] tx_q[$];
  route_t tx_route_q[$];
  logic [BEAT_W-1:0] cpu_src_q[$];
  logic [BEAT_W-1:0] xi_src_q[$];

  eth_switch dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  function automatic logic [BEAT_W-1:0] random_beat(input logic last);
    logic [31:0] r;
    r = rand32();
    random_beat = {last, 1'b0, r[2:0], rand32(), rand32()};
  endfunction

  task automatic check_reg(input string name, input logic [REG_DW-1:0] got,
                           input logic [REG_DW-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_error("Register read-back mismatch");
    end
  endtask

  task automatic check_beat(input string name, input logic [DATA_W-1:0] got_d,
                            input logic [USER_W-1:0] got_u, input logic got_l,
                            input logic [DATA_W-1:0] exp_d,
                            input logic [USER_W-1:0] exp_u, input logic exp_l);
    if (got_d !== exp_d || got_u !== exp_u || got_l !== exp_l) begin
      $display("FAIL %s data 0x%h user 0x%h last 0x%h", name, got_d, got_u, got_l);
      $display("  expected data 0x%h user 0x%h last 0x%h", exp_d, exp_u, exp_l);
      stop_with_error("Output beat differs from the packet that was sent");
    end
  endtask

  task automatic check_route(input string name, input route_t got, input route_t exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_error("Beat left on the wrong port");
    end
  endtask

  task automatic take_beat(input string name, input bit tx, input route_t port,
                           input logic [DATA_W-1:0] d, input logic [USER_W-1:0] u,
                           input logic l);
    logic [BEAT_W-1:0] w;
    route_t r;
    if (tx ? (tx_q.size() == 0) : (rx_q.size() == 0)) begin
      stop_with_error({"Unexpected beat on ", name});
    end else begin
      if (tx) begin
        w = tx_q.pop_front();
        r = tx_route_q.pop_front();
      end else begin
        w = rx_q.pop_front();
        r = rx_route_q.pop_front();
      end
      check_route({name, " port"}, port, r);
      check_beat(name, d, u, l, w[DATA_W-1:0], w[BEAT_W-2:DATA_W], w[BEAT_W-1]);
    end
  endtask

  // Output monitor samples mid-cycle where everything is settled
  always @(negedge clk) begin
    if (o_e2c_tvalid && i_e2c_tready) begin
      take_beat("o_e2c", 1'b0, ROUTE_CPU, o_e2c_tdata, o_e2c_tuser, o_e2c_tlast);
    end
    if (o_xo_tvalid && i_xo_tready) begin
      take_beat("o_xo", 1'b0, ROUTE_XO, o_xo_tdata, o_xo_tuser, o_xo_tlast);
    end
    if (o_eth_tx_tvalid && i_eth_tx_tready) begin
      tx_src = o_xi_tready ? ROUTE_XO : ROUTE_CPU;
      take_beat("o_eth_tx", 1'b1, tx_src, o_eth_tx_tdata, o_eth_tx_tuser, o_eth_tx_tlast);
    end
  end

  // Random back-pressure with outputs ready about 75% of the time
  always @(posedge clk) begin
    ready_bits      = rand32();
    #1;
    i_e2c_tready    = ready_bits[0] | ready_bits[1];
    i_xo_tready     = ready_bits[2] | ready_bits[3];
    i_eth_tx_tready = ready_bits[4] | ready_bits[5];
  end

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
    i_reg_wr_req  = 1'b1;
    i_reg_wr_addr = addr;
    i_reg_wr_data = data;
    next_cycle();
    i_reg_wr_req = 1'b0;
  endtask

  // Response is due exactly one cycle after the request
  task automatic reg_read(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] exp);
    i_reg_rd_req  = 1'b1;
    i_reg_rd_addr = addr;
    next_cycle();
    i_reg_rd_req = 1'b0;
    @(negedge clk);
    if (o_reg_rd_resp !== 1'b1) begin
      stop_with_error($sformatf("No read response for offset 0x%h", addr));
    end
    check_reg($sformatf("o_reg_rd_data @0x%h", addr), o_reg_rd_data, exp);
    next_cycle();
  endtask

  task automatic no_read_response(input logic [REG_AW-1:0] addr);
    i_reg_rd_req  = 1'b1;
    i_reg_rd_addr = addr;
    next_cycle();
    i_reg_rd_req = 1'b0;
    @(negedge clk);
    if (o_reg_rd_resp !== 1'b0) begin
      stop_with_error($sformatf("Unmapped offset 0x%h gave a read response", addr));
    end
    next_cycle();
  endtask

  task automatic send_rx(input logic [MAC_W-1:0] dst, input bit err);
    logic [BEAT_W-1:0] w;
    logic [31:0] r;
    int n;
    int b;
    int t;
    r = rand32();
    n = 1 + int'(r[2:0]);
    for (b = 0; b < n; b++) begin
      w = random_beat(b == n - 1);
      if (b == 0) w[MAC_W-1:0] = dst;
      if (err && b == n - 1) w[DATA_W+USER_ERR_BIT] = 1'b1;
      if (!err) begin
        rx_q.push_back(w);
        rx_route_q.push_back((dst == model_mac) ? ROUTE_CPU : ROUTE_XO);
      end
      {i_eth_rx_tlast, i_eth_rx_tuser, i_eth_rx_tdata} = w;
      i_eth_rx_tvalid = 1'b1;
      t = 0;
      do begin
        @(negedge clk);
        t++;
        if (t > TIMEOUT) stop_with_error("Timed out waiting for o_eth_rx_tready");
      end while (!o_eth_rx_tready);
      next_cycle();
    end
    i_eth_rx_tvalid = 1'b0;
  endtask

  task automatic drive_source(input route_t src);
    logic [BEAT_W-1:0] w;
    int t;
    while ((src == ROUTE_CPU) ? (cpu_src_q.size() > 0) : (xi_src_q.size() > 0)) begin
      if (src == ROUTE_CPU) begin
        w = cpu_src_q.pop_front();
        {i_c2e_tlast, i_c2e_tuser, i_c2e_tdata} = w;
        i_c2e_tvalid = 1'b1;
      end else begin
        w = xi_src_q.pop_front();
        {i_xi_tlast, i_xi_tuser, i_xi_tdata} = w;
        i_xi_tvalid = 1'b1;
      end
      t = 0;
      do begin
        @(negedge clk);
        t++;
        if (t > TIMEOUT) stop_with_error("Timed out waiting for a transmit grant");
      end while (!((src == ROUTE_CPU) ? o_c2e_tready : o_xi_tready));
      next_cycle();
    end
    if (src == ROUTE_CPU) i_c2e_tvalid = 1'b0;
    else i_xi_tvalid = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int t;
    t = 0;
    while (rx_q.size() != 0 || tx_q.size() != 0) begin
      @(negedge clk);
      t++;
      if (t > TIMEOUT) stop_with_error({what, ": expected packets never arrived"});
    end
    next_cycle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_register_map();
    logic [31:0] lsb;
    logic [31:0] msb;
    reg_read(REG_MAC_LSB, DEFAULT_MAC[31:0]);
    reg_read(REG_MAC_MSB, {16'h0, DEFAULT_MAC[47:32]});
    reg_read(REG_BRIDGE_MAC_LSB, DEFAULT_MAC[31:0]);
    reg_read(REG_BRIDGE_MAC_MSB, {16'h0, DEFAULT_MAC[47:32]});
    reg_read(REG_BRIDGE_ENABLE, 32'h0);
    lsb = rand32();
    msb = rand32() | 32'hffff_0000;
    reg_write(REG_MAC_LSB, lsb);
    reg_write(REG_MAC_MSB, msb);
    reg_read(REG_MAC_LSB, lsb);
    reg_read(REG_MAC_MSB, {16'h0, msb[15:0]});
    // Device MAC goes back to its default for the packet tests
    reg_write(REG_MAC_LSB, DEFAULT_MAC[31:0]);
    reg_write(REG_MAC_MSB, {16'h0, DEFAULT_MAC[47:32]});
    lsb = rand32();
    msb = rand32() | 32'hffff_0000;
    reg_write(REG_BRIDGE_MAC_LSB, lsb);
    reg_write(REG_BRIDGE_MAC_MSB, msb);
    reg_read(REG_BRIDGE_MAC_LSB, lsb);
    reg_read(REG_BRIDGE_MAC_MSB, {16'h0, msb[15:0]});
    reg_write(REG_BRIDGE_ENABLE, 32'hffff_ffff);
    reg_read(REG_BRIDGE_ENABLE, 32'h1);
    reg_write(REG_BRIDGE_ENABLE, 32'h0);
    // Unmapped write must not alias onto the MAC
    reg_write(14'h0008, 32'hdead_beef);
    reg_read(REG_MAC_LSB, DEFAULT_MAC[31:0]);
    no_read_response(14'h0008);
    no_read_response(14'h1024);
  endtask

  task automatic test_dispatch();
    logic [31:0] r;
    int i;
    for (i = 0; i < 10; i++) begin
      r = rand32();
      if (r[31]) send_rx(model_mac, 1'b0);
      else send_rx({r[15:0], rand32()}, 1'b0);
    end
    wait_drain("dispatch");
  endtask

  task automatic test_bridge_mode();
    logic [MAC_W-1:0] bridge_mac;
    logic [31:0] r;
    r = rand32();
    bridge_mac = {r[15:0], rand32()};
    reg_write(REG_BRIDGE_MAC_LSB, bridge_mac[31:0]);
    reg_write(REG_BRIDGE_MAC_MSB, {16'h0, bridge_mac[47:32]});
    reg_write(REG_BRIDGE_ENABLE, 32'h1);
    model_mac = bridge_mac;
    send_rx(bridge_mac, 1'b0);
    send_rx(DEFAULT_MAC, 1'b0);
    send_rx(bridge_mac, 1'b0);
    wait_drain("bridge enabled");
    reg_write(REG_BRIDGE_ENABLE, 32'h0);
    model_mac = DEFAULT_MAC;
    send_rx(DEFAULT_MAC, 1'b0);
    send_rx(bridge_mac, 1'b0);
    wait_drain("bridge disabled");
  endtask

  task automatic test_error_drop();
    send_rx(DEFAULT_MAC, 1'b0);
    send_rx(DEFAULT_MAC, 1'b1);
    send_rx(48'h0a0b_0c0d_0e0f, 1'b1);
    send_rx(48'h0a0b_0c0d_0e0f, 1'b0);
    send_rx(DEFAULT_MAC, 1'b0);
    wait_drain("error drop");
  endtask

  // Both sources stay busy, so grants must alternate CPU, crossover, CPU...
  task automatic test_tx_merge();
    logic [BEAT_W-1:0] w;
    logic [31:0] r;
    int p;
    int s;
    int b;
    int n;
    for (p = 0; p < 4; p++) begin
      for (s = 0; s < 2; s++) begin
        r = rand32();
        n = 1 + int'(r[2:0]);
        for (b = 0; b < n; b++) begin
          w = random_beat(b == n - 1);
          tx_q.push_back(w);
          tx_route_q.push_back((s == 0) ? ROUTE_CPU : ROUTE_XO);
          if (s == 0) cpu_src_q.push_back(w);
          else xi_src_q.push_back(w);
        end
      end
    end
    fork
      drive_source(ROUTE_CPU);
      drive_source(ROUTE_XO);
    join
    wait_drain("transmit merge");
  endtask

  initial begin
    seed = 32'he0f0;
    model_mac = DEFAULT_MAC;
    reset = 1'b1;
    i_reg_wr_req = 1'b0;
    i_reg_wr_addr = '0;
    i_reg_wr_data = '0;
    i_reg_rd_req = 1'b0;
    i_reg_rd_addr = '0;
    {i_eth_rx_tdata, i_eth_rx_tuser, i_eth_rx_tlast, i_eth_rx_tvalid} = '0;
    {i_c2e_tdata, i_c2e_tuser, i_c2e_tlast, i_c2e_tvalid} = '0;
    {i_xi_tdata, i_xi_tuser, i_xi_tlast, i_xi_tvalid} = '0;
    i_e2c_tready = 1'b1;
    i_xo_tready = 1'b1;
    i_eth_tx_tready = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    next_cycle();
    test_register_map();
    test_dispatch();
    test_bridge_mode();
    test_error_drop();
    test_tx_merge();
    // Idle tail lets the monitor catch any stray beat
    repeat (20) next_cycle();
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- verilog.f
eth_switch_pkg.sv
eth_reg_file.sv
eth_packet_gate.sv
eth_dispatch.sv
eth_tx_arbiter.sv
eth_switch.sv
tb_eth_switch.sv
